//--- vga_pkg.sv
// vga pipeline shared definitions
package vga_pkg;

  // 4:4:4 rgb colours
  localparam logic [11:0] COL_BLACK  = 12'h000;
  localparam logic [11:0] COL_YELLOW = 12'hff0;  // top edge
  localparam logic [11:0] COL_RED    = 12'hf00;  // bottom edge
  localparam logic [11:0] COL_GREEN  = 12'h0f0;  // left edge
  localparam logic [11:0] COL_BLUE   = 12'h00f;  // right edge and markers
  localparam logic [11:0] COL_GRAY   = 12'h888;  // fill
  localparam logic [11:0] COL_RECT   = 12'hf0f;  // overlay rectangle

  // 800x600 raster, default parameter values only
  localparam int HOR_PIXELS  = 800;
  localparam int HOR_TOTAL   = 1056;
  localparam int HSYNC_START = 840;
  localparam int HSYNC_LEN   = 128;
  localparam int VER_PIXELS  = 600;
  localparam int VER_TOTAL   = 628;
  localparam int VSYNC_START = 601;
  localparam int VSYNC_LEN   = 4;

  localparam int MARKER_X_DEF = 550;  // first marker column
  localparam int RECT_W_DEF   = 48;
  localparam int RECT_H_DEF   = 64;

  // host command opcodes
  typedef enum logic [1:0] {
    OP_NOP       = 2'd0,
    OP_SET_X     = 2'd1,  // rectangle left column
    OP_SET_Y     = 2'd2,  // rectangle top row
    OP_SET_TOTAL = 2'd3   // marker offset, low 6 bits
  } cmd_op_t;

  // rect_ctl FSM
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_PENDING = 2'd1,
    ST_COMMIT  = 2'd2
  } ctl_state_t;

endpackage

//--- vga_timing.sv
// vga raster timing generator
module vga_timing #(
  parameter int HOR_PIXELS  = vga_pkg::HOR_PIXELS,
  parameter int HOR_TOTAL   = vga_pkg::HOR_TOTAL,
  parameter int HSYNC_START = vga_pkg::HSYNC_START,
  parameter int HSYNC_LEN   = vga_pkg::HSYNC_LEN,
  parameter int VER_PIXELS  = vga_pkg::VER_PIXELS,
  parameter int VER_TOTAL   = vga_pkg::VER_TOTAL,
  parameter int VSYNC_START = vga_pkg::VSYNC_START,
  parameter int VSYNC_LEN   = vga_pkg::VSYNC_LEN
) (
  input  logic        clk,
  input  logic        rst,
  output logic [10:0] hcount,
  output logic [10:0] vcount,
  output logic        hsync,
  output logic        vsync,
  output logic        hblnk,
  output logic        vblnk
);

  localparam logic [10:0] H_LAST    = 11'(HOR_TOTAL - 1);
  localparam logic [10:0] V_LAST    = 11'(VER_TOTAL - 1);
  localparam logic [10:0] HS_BEGIN  = 11'(HSYNC_START);
  localparam logic [10:0] HS_END    = 11'(HSYNC_START + HSYNC_LEN);
  localparam logic [10:0] VS_BEGIN  = 11'(VSYNC_START);
  localparam logic [10:0] VS_END    = 11'(VSYNC_START + VSYNC_LEN);
  localparam logic [10:0] H_VISIBLE = 11'(HOR_PIXELS);
  localparam logic [10:0] V_VISIBLE = 11'(VER_PIXELS);

  logic [10:0] hcount_nxt;
  logic [10:0] vcount_nxt;
  logic        line_end;

  assign line_end = (hcount == H_LAST);

  // next position, flags are derived from it so all outputs stay registered
  always_comb begin
    hcount_nxt = line_end ? 11'd0 : hcount + 11'd1;
    vcount_nxt = vcount;
    if (line_end) begin
      if (vcount == V_LAST) begin
        vcount_nxt = 11'd0;  // frame wrap
      end else begin
        vcount_nxt = vcount + 11'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hcount <= 11'd0;
      vcount <= 11'd0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
    end else begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hblnk  <= (hcount_nxt >= H_VISIBLE);  // outside active columns
      vblnk  <= (vcount_nxt >= V_VISIBLE);  // outside active rows
      hsync  <= (hcount_nxt >= HS_BEGIN) && (hcount_nxt < HS_END);
      vsync  <= (vcount_nxt >= VS_BEGIN) && (vcount_nxt < VS_END);
    end
  end

  // counter must wrap before leaving the line
  a_hcount_range: assert property (
    @(posedge clk) disable iff (rst) hcount <= H_LAST
  );

endmodule

//--- draw_bg.sv
// background, borders and markers
module draw_bg import vga_pkg::*; #(
  parameter int HOR_PIXELS = vga_pkg::HOR_PIXELS,
  parameter int VER_PIXELS = vga_pkg::VER_PIXELS,
  parameter int MARKER_X   = MARKER_X_DEF
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [5:0]  total,
  input  logic [10:0] hcount_in,
  input  logic [10:0] vcount_in,
  input  logic        hsync_in,
  input  logic        vsync_in,
  input  logic        hblnk_in,
  input  logic        vblnk_in,
  output logic [10:0] hcount_out,
  output logic [10:0] vcount_out,
  output logic        hsync_out,
  output logic        vsync_out,
  output logic        hblnk_out,
  output logic        vblnk_out,
  output logic [11:0] rgb_out
);

  localparam logic [10:0] LAST_COL = 11'(HOR_PIXELS - 1);
  localparam logic [10:0] LAST_ROW = 11'(VER_PIXELS - 1);
  localparam logic [10:0] MARK_A   = 11'(MARKER_X);

  logic [11:0] rgb_nxt;
  logic [10:0] mark_b;

  assign mark_b = MARK_A + 11'(total);  // second marker trails the first

  always_comb begin
    if (hblnk_in || vblnk_in) begin
      rgb_nxt = COL_BLACK;
    end else if (vcount_in == 11'd0) begin
      rgb_nxt = COL_YELLOW;  // top edge
    end else if (vcount_in == LAST_ROW) begin
      rgb_nxt = COL_RED;  // bottom edge
    end else if (hcount_in == 11'd0) begin
      rgb_nxt = COL_GREEN;  // left edge
    end else if (hcount_in == LAST_COL) begin
      rgb_nxt = COL_BLUE;  // right edge
    end else if ((hcount_in == MARK_A) || (hcount_in == mark_b)) begin
      rgb_nxt = COL_BLUE;  // markers
    end else begin
      rgb_nxt = COL_GRAY;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hcount_out <= 11'd0;
      vcount_out <= 11'd0;
      hsync_out  <= 1'b0;
      vsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      rgb_out    <= COL_BLACK;
    end else begin
      hcount_out <= hcount_in;
      vcount_out <= vcount_in;
      hsync_out  <= hsync_in;
      vsync_out  <= vsync_in;
      hblnk_out  <= hblnk_in;
      vblnk_out  <= vblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

endmodule

//--- draw_rect.sv
// filled rectangle overlay
module draw_rect import vga_pkg::*; #(
  parameter int RECT_W = RECT_W_DEF,
  parameter int RECT_H = RECT_H_DEF
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [10:0] rect_x,
  input  logic [10:0] rect_y,
  input  logic [10:0] hcount_in,
  input  logic [10:0] vcount_in,
  input  logic        hsync_in,
  input  logic        vsync_in,
  input  logic        hblnk_in,
  input  logic        vblnk_in,
  input  logic [11:0] rgb_in,
  output logic [10:0] hcount_out,
  output logic [10:0] vcount_out,
  output logic        hsync_out,
  output logic        vsync_out,
  output logic        hblnk_out,
  output logic        vblnk_out,
  output logic [11:0] rgb_out
);

  logic [11:0] x_end;  // one bit wider, rect may run past the counter range
  logic [11:0] y_end;
  logic        in_cols;
  logic        in_rows;
  logic        blank;
  logic [11:0] rgb_nxt;

  assign x_end = {1'b0, rect_x} + 12'(RECT_W);
  assign y_end = {1'b0, rect_y} + 12'(RECT_H);

  assign in_cols = (hcount_in >= rect_x) && ({1'b0, hcount_in} < x_end);
  assign in_rows = (vcount_in >= rect_y) && ({1'b0, vcount_in} < y_end);
  assign blank   = hblnk_in || vblnk_in;

  // overlay wins over borders and markers
  always_comb begin
    rgb_nxt = rgb_in;
    if (!blank && in_cols && in_rows) begin
      rgb_nxt = COL_RECT;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hcount_out <= 11'd0;
      vcount_out <= 11'd0;
      hsync_out  <= 1'b0;
      vsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      rgb_out    <= COL_BLACK;
    end else begin
      hcount_out <= hcount_in;
      vcount_out <= vcount_in;
      hsync_out  <= hsync_in;
      vsync_out  <= vsync_in;
      hblnk_out  <= hblnk_in;
      vblnk_out  <= vblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

  // whole pipeline keeps blanking dark, relies on the stage before too
  a_blank_black: assert property (
    @(posedge clk) disable iff (rst)
    (hblnk_out || vblnk_out) |-> (rgb_out == COL_BLACK)
  );

endmodule

//--- rect_ctl.sv
// host command port with frame-synchronous commit
module rect_ctl import vga_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cmd_valid,
  input  cmd_op_t     cmd_op,
  input  logic [10:0] cmd_arg,
  input  logic        vblnk,
  output logic        cmd_ready,
  output logic [5:0]  total,
  output logic [10:0] rect_x,
  output logic [10:0] rect_y
);

  ctl_state_t  state;
  ctl_state_t  state_nxt;
  logic        vblnk_d;
  logic        vblnk_rise;
  logic        cmd_accept;
  logic [5:0]  shadow_total;
  logic [10:0] shadow_x;
  logic [10:0] shadow_y;

  assign cmd_ready  = (state != ST_COMMIT);  // one-cycle stall while copying
  assign cmd_accept = cmd_valid && cmd_ready;
  assign vblnk_rise = vblnk && !vblnk_d;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (cmd_accept && vblnk_rise) begin
          state_nxt = ST_COMMIT;  // fresh command still makes this blank
        end else if (cmd_accept) begin
          state_nxt = ST_PENDING;
        end
      end
      ST_PENDING: begin
        if (vblnk_rise) begin
          state_nxt = ST_COMMIT;
        end
      end
      ST_COMMIT: state_nxt = ST_IDLE;
      default:   state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      vblnk_d <= 1'b0;
    end else begin
      state   <= state_nxt;
      vblnk_d <= vblnk;
    end
  end

  // shadow copies, last write per opcode wins
  always_ff @(posedge clk) begin
    if (rst) begin
      shadow_total <= 6'd0;
      shadow_x     <= 11'd0;
      shadow_y     <= 11'd0;
    end else if (cmd_accept) begin
      case (cmd_op)
        OP_SET_X:     shadow_x     <= cmd_arg;
        OP_SET_Y:     shadow_y     <= cmd_arg;
        OP_SET_TOTAL: shadow_total <= cmd_arg[5:0];
        default:      ;  // nop
      endcase
    end
  end

  // live values seen by the drawing stages
  always_ff @(posedge clk) begin
    if (rst) begin
      total  <= 6'd0;
      rect_x <= 11'd0;
      rect_y <= 11'd0;
    end else if (state == ST_COMMIT) begin
      total  <= shadow_total;
      rect_x <= shadow_x;
      rect_y <= shadow_y;
    end
  end

  // no tearing: updates land only inside vertical blanking
  a_live_in_blank: assert property (
    @(posedge clk) disable iff (rst)
    $changed({total, rect_x, rect_y}) |-> $past(vblnk)
  );

endmodule

//--- vga_top.sv
// vga display pipeline top
module vga_top import vga_pkg::*; #(
  parameter int HOR_PIXELS  = vga_pkg::HOR_PIXELS,
  parameter int HOR_TOTAL   = vga_pkg::HOR_TOTAL,
  parameter int HSYNC_START = vga_pkg::HSYNC_START,
  parameter int HSYNC_LEN   = vga_pkg::HSYNC_LEN,
  parameter int VER_PIXELS  = vga_pkg::VER_PIXELS,
  parameter int VER_TOTAL   = vga_pkg::VER_TOTAL,
  parameter int VSYNC_START = vga_pkg::VSYNC_START,
  parameter int VSYNC_LEN   = vga_pkg::VSYNC_LEN,
  parameter int MARKER_X    = MARKER_X_DEF,
  parameter int RECT_W      = RECT_W_DEF,
  parameter int RECT_H      = RECT_H_DEF
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        cmd_valid,
  input  cmd_op_t     cmd_op,
  input  logic [10:0] cmd_arg,
  output logic        cmd_ready,
  output logic [10:0] hcount,
  output logic [10:0] vcount,
  output logic        hsync,
  output logic        vsync,
  output logic        hblnk,
  output logic        vblnk,
  output logic [11:0] rgb
);

  // timing generator outputs
  logic [10:0] tim_hcount;
  logic [10:0] tim_vcount;
  logic        tim_hsync;
  logic        tim_vsync;
  logic        tim_hblnk;
  logic        tim_vblnk;

  // background stage outputs
  logic [10:0] bg_hcount;
  logic [10:0] bg_vcount;
  logic        bg_hsync;
  logic        bg_vsync;
  logic        bg_hblnk;
  logic        bg_vblnk;
  logic [11:0] bg_rgb;

  // live configuration
  logic [5:0]  total;
  logic [10:0] rect_x;
  logic [10:0] rect_y;

  vga_timing #(
    .HOR_PIXELS  (HOR_PIXELS),
    .HOR_TOTAL   (HOR_TOTAL),
    .HSYNC_START (HSYNC_START),
    .HSYNC_LEN   (HSYNC_LEN),
    .VER_PIXELS  (VER_PIXELS),
    .VER_TOTAL   (VER_TOTAL),
    .VSYNC_START (VSYNC_START),
    .VSYNC_LEN   (VSYNC_LEN)
  ) u_vga_timing (
    .clk    (clk),
    .rst    (rst),
    .hcount (tim_hcount),
    .vcount (tim_vcount),
    .hsync  (tim_hsync),
    .vsync  (tim_vsync),
    .hblnk  (tim_hblnk),
    .vblnk  (tim_vblnk)
  );

  rect_ctl u_rect_ctl (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_arg   (cmd_arg),
    .vblnk     (tim_vblnk),  // commit follows the generator, not the delayed stream
    .cmd_ready (cmd_ready),
    .total     (total),
    .rect_x    (rect_x),
    .rect_y    (rect_y)
  );

  draw_bg #(
    .HOR_PIXELS (HOR_PIXELS),
    .VER_PIXELS (VER_PIXELS),
    .MARKER_X   (MARKER_X)
  ) u_draw_bg (
    .clk        (clk),
    .rst        (rst),
    .total      (total),
    .hcount_in  (tim_hcount),
    .vcount_in  (tim_vcount),
    .hsync_in   (tim_hsync),
    .vsync_in   (tim_vsync),
    .hblnk_in   (tim_hblnk),
    .vblnk_in   (tim_vblnk),
    .hcount_out (bg_hcount),
    .vcount_out (bg_vcount),
    .hsync_out  (bg_hsync),
    .vsync_out  (bg_vsync),
    .hblnk_out  (bg_hblnk),
    .vblnk_out  (bg_vblnk),
    .rgb_out    (bg_rgb)
  );

  draw_rect #(
    .RECT_W (RECT_W),
    .RECT_H (RECT_H)
  ) u_draw_rect (
    .clk        (clk),
    .rst        (rst),
    .rect_x     (rect_x),
    .rect_y     (rect_y),
    .hcount_in  (bg_hcount),
    .vcount_in  (bg_vcount),
    .hsync_in   (bg_hsync),
    .vsync_in   (bg_vsync),
    .hblnk_in   (bg_hblnk),
    .vblnk_in   (bg_vblnk),
    .rgb_in     (bg_rgb),
    .hcount_out (hcount),
    .vcount_out (vcount),
    .hsync_out  (hsync),
    .vsync_out  (vsync),
    .hblnk_out  (hblnk),
    .vblnk_out  (vblnk),
    .rgb_out    (rgb)
  );

endmodule

//--- tb_vga_top.sv
// vga pipeline testbench
module tb_vga_top import vga_pkg::*; ();

  // tiny raster keeps whole frames short
  localparam int H_PIX    = 16;
  localparam int H_TOT    = 20;
  localparam int HS_START = 17;
  localparam int HS_LEN   = 2;
  localparam int V_PIX    = 8;
  localparam int V_TOT    = 11;
  localparam int VS_START = 9;
  localparam int VS_LEN   = 1;
  localparam int MARK_X   = 6;
  localparam int R_W      = 3;
  localparam int R_H      = 2;

  localparam int CLK_PERIOD   = 20;
  localparam int FRAME_CYCLES = H_TOT * V_TOT;
  localparam int CYCLE_LIMIT  = 8 * FRAME_CYCLES + 100;  // pattern spans under 8 frames
  localparam int PAT_DEPTH    = 64;

  logic        clk;
  logic        rst;
  logic        cmd_valid;
  cmd_op_t     cmd_op;
  logic [10:0] cmd_arg;
  logic        cmd_ready;
  logic [10:0] hcount;
  logic [10:0] vcount;
  logic        hsync;
  logic        vsync;
  logic        hblnk;
  logic        vblnk;
  logic [11:0] rgb;

  logic        hblnk_exp;
  logic        vblnk_exp;
  logic        hsync_exp;
  logic        vsync_exp;

  logic [31:0] patterns [0:PAT_DEPTH-1];
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;

  vga_top #(
    .HOR_PIXELS  (H_PIX),
    .HOR_TOTAL   (H_TOT),
    .HSYNC_START (HS_START),
    .HSYNC_LEN   (HS_LEN),
    .VER_PIXELS  (V_PIX),
    .VER_TOTAL   (V_TOT),
    .VSYNC_START (VS_START),
    .VSYNC_LEN   (VS_LEN),
    .MARKER_X    (MARK_X),
    .RECT_W      (R_W),
    .RECT_H      (R_H)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_arg   (cmd_arg),
    .cmd_ready (cmd_ready),
    .hcount    (hcount),
    .vcount    (vcount),
    .hsync     (hsync),
    .vsync     (vsync),
    .hblnk     (hblnk),
    .vblnk     (vblnk),
    .rgb       (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // blanking must always be dark
  always @(negedge clk) begin
    if (!rst && (hblnk || vblnk)) begin
      if (rgb !== 12'h000) begin
        $display("mismatch rgb in blanking at (%0d,%0d): got %h expected %h",
                 hcount, vcount, rgb, 12'h000);
        error_count++;
      end
    end
  end

  // flags expected for the position they leave with
  assign hblnk_exp = (hcount >= H_PIX);
  assign vblnk_exp = (vcount >= V_PIX);
  assign hsync_exp = (hcount >= HS_START) && (hcount < HS_START + HS_LEN);
  assign vsync_exp = (vcount >= VS_START) && (vcount < VS_START + VS_LEN);

  always @(negedge clk) begin
    if (!rst) begin
      if (hblnk !== hblnk_exp) begin
        $display("mismatch hblnk at (%0d,%0d): got %h expected %h",
                 hcount, vcount, hblnk, hblnk_exp);
        error_count++;
      end
      if (vblnk !== vblnk_exp) begin
        $display("mismatch vblnk at (%0d,%0d): got %h expected %h",
                 hcount, vcount, vblnk, vblnk_exp);
        error_count++;
      end
      if (hsync !== hsync_exp) begin
        $display("mismatch hsync at (%0d,%0d): got %h expected %h",
                 hcount, vcount, hsync, hsync_exp);
        error_count++;
      end
      if (vsync !== vsync_exp) begin
        $display("mismatch vsync at (%0d,%0d): got %h expected %h",
                 hcount, vcount, vsync, vsync_exp);
        error_count++;
      end
    end
  end

  task automatic wait_vblnk_rise();
    logic last;
    last = vblnk;
    @(negedge clk);
    while (!(vblnk && !last)) begin
      last = vblnk;
      @(negedge clk);
    end
  endtask

  // second rise guarantees a commit has landed before the checked frame
  task automatic sync_to_new_frame();
    wait_vblnk_rise();
    wait_vblnk_rise();
  endtask

  task automatic check_pixel(input logic [10:0] h, input logic [10:0] v,
                             input logic [11:0] exp_rgb);
    @(negedge clk);
    while (!(hcount == h && vcount == v)) begin
      @(negedge clk);
    end
    check_count++;
    if (rgb !== exp_rgb) begin
      $display("mismatch rgb at (%0d,%0d): got %h expected %h", h, v, rgb, exp_rgb);
      error_count++;
    end
  endtask

  task automatic send_cmd(input cmd_op_t op, input logic [10:0] arg);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_arg   = arg;
    while (!cmd_ready) begin
      @(negedge clk);
    end
    @(negedge clk);  // transfer took place on the rising edge before
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
    cmd_arg   = 11'd0;
  endtask

  initial begin
    int          idx;
    logic [31:0] word;
    logic        done;
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
    cmd_arg   = 11'd0;
    $readmemh("vga_patterns.txt", patterns);
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (cmd_ready !== 1'b1) begin
      $display("mismatch cmd_ready after reset: got %h expected %h", cmd_ready, 1'b1);
      error_count++;
    end
    idx  = 0;
    done = 1'b0;
    if (^patterns[0] === 1'bx) begin
      $display("pattern file vga_patterns.txt is missing or empty");
      error_count++;
      done = 1'b1;
    end
    while (!done) begin
      word = patterns[idx];
      if (^word === 1'bx) begin
        $display("pattern file has no end marker, stopped at word %0d", idx);
        error_count++;
        done = 1'b1;
      end else begin
        case (word[31:28])
          4'h1: send_cmd(cmd_op_t'(word[25:24]), word[10:0]);
          4'h2: sync_to_new_frame();
          4'h3: check_pixel({3'd0, word[27:20]}, {3'd0, word[19:12]}, word[11:0]);
          4'hf: done = 1'b1;
          default: begin
            $display("unknown pattern word %h at index %0d", word, idx);
            error_count++;
            done = 1'b1;
          end
        endcase
      end
      idx++;
      if (idx >= PAT_DEPTH) begin
        done = 1'b1;
      end
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vga_patterns.txt
// 1O000AAA command, O opcode, AAA arg | 20000000 wait two vblnk rises
// 3HHVVRGB check rgb at column HH row VV | f0000000 end of list
20000000
30300ff0
30202888
31002000
300030f0
30f0300f
3060400f
30904888
30307f00
30509000
30301888
13000003
1100000a
12000003
30b03888
30905888
20000000
3060200f
30802888
3090200f
30a03f0f
30d03888
30c04f0f
30b05888
1100000e
12000006
10000000
30f0600f
20000000
3090300f
30a03888
30d06888
30e06f0f
30f06f0f
31006000
30d07f00
30e07f0f
f0000000

//--- filelist.f
vga_pkg.sv
vga_timing.sv
draw_bg.sv
draw_rect.sv
rect_ctl.sv
vga_top.sv
tb_vga_top.sv
